// File: dv/render_tests.txt
# name cam_x cam_y cam_z box_xmin box_xmax box_ymin box_ymax box_zmin stall_density
# stall_density 0 to 3 is the chance of pix_stall per cycle in quarters
full_view         0   0   0   -10   10   -6    6   2   0
partial_cut       0   0   0     4   40  -20    2   1   0
behind_camera     0   0  10   -50   50  -50   50   5   0
t_zero            0   0   4   -50   50  -50   50   4   0
full_stall_1      0   0   0   -10   10   -6    6   2   1
partial_stall_2   0   0   0     4   40  -20    2   1   2
behind_stall_3    0   0  10   -50   50  -50   50   5   3
offset_camera    20  -3  -2     5   30  -10    0   1   2
far_box           0   0  -3   -12   12   -9    9   2   3
corner_box       -4   2   0   -20   -6    3   30   1   1
single_pixel      0   0   0     0    0    0    0   1   3
whole_view        0   0   0  -100  100 -100  100   3   2
t_zero_stall_3    0   0   4   -50   50  -50   50   4   3
full_view_again   0   0   0   -10   10   -6    6   2   2

// File: render_top.f
hw/rt_pkg.sv
hw/frame_sequencer.sv
hw/ray_gen.sv
hw/scene_int.sv
hw/pixel_arbiter.sv
hw/pixel_fifo.sv
hw/render_top.sv
dv/render_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the render engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module render_tb -f render_top.f -o render_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/render_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: dv/render_tb.sv
// Render engine testbench
`timescale 1ns/10ps

module render_tb;
	import rt_pkg::*;

	localparam int IMG_W = 16;
	localparam int IMG_H = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int PIXELS = IMG_W * IMG_H;
	localparam int START_TIMEOUT = 10;
	localparam int FRAME_TIMEOUT = 20000;
	localparam int IDLE_CYCLES = 8;

	logic      clk;
	logic      rst_n;
	logic      start;
	coord_t    cam_x;
	coord_t    cam_y;
	coord_t    cam_z;
	coord_t    box_xmin;
	coord_t    box_xmax;
	coord_t    box_ymin;
	coord_t    box_ymax;
	coord_t    box_zmin;
	logic      pix_valid;
	logic      pix_stall;
	pixel_id_t pix_id;
	color_t    pix_color;
	logic      busy;
	logic      frame_done;

	// Current test, as read from the test file
	string cur_name;
	int    v_cam_x;
	int    v_cam_y;
	int    v_cam_z;
	int    v_xmin;
	int    v_xmax;
	int    v_ymin;
	int    v_ymax;
	int    v_zmin;
	int    density;

	// Reference image and delivery record
	color_t exp_color [PIXELS];
	logic   seen [PIXELS];

	logic [15:0] lfsr_state;
	int          mismatch_cnt;
	int          proto_cnt;
	int          timeout_cnt;
	logic        aborted;

	render_top #(
		.IMG_W(IMG_W),
		.IMG_H(IMG_H),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.clk, .rst_n, .start,
		.cam_x, .cam_y, .cam_z,
		.box_xmin, .box_xmax, .box_ymin, .box_ymax, .box_zmin,
		.pix_valid, .pix_stall, .pix_id, .pix_color, .busy, .frame_done
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	function automatic logic rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		return b;
	endfunction

	// Stall with a chance of dens quarters
	function automatic logic draw_stall(input int dens);
		logic [1:0] r;
		r[0] = rand_bit();
		r[1] = rand_bit();
		return int'(r) < dens;
	endfunction

	// Box front face hit test for every pixel of the image
	function automatic void build_expected();
		int t;
		int x;
		int y;
		int px;
		int py;
		t = v_zmin - v_cam_z;
		for (y = 0; y < IMG_H; y++) begin
			for (x = 0; x < IMG_W; x++) begin
				px = v_cam_x + (x - IMG_W / 2) * t;
				py = v_cam_y + (y - IMG_H / 2) * t;
				if (t > 0 && px >= v_xmin && px <= v_xmax && py >= v_ymin && py <= v_ymax)
					exp_color[y * IMG_W + x] = HIT_COLOR;
				else
					exp_color[y * IMG_W + x] = MISS_COLOR;
				seen[y * IMG_W + x] = 1'b0;
			end
		end
	endfunction

	task automatic check_id(input pixel_id_t id);
		if (int'(id) >= PIXELS) begin
			mismatch_cnt++;
			$display("MISMATCH %s: pixel id expected 0 to %0d, got %0d", cur_name, PIXELS - 1, id);
		end else if (seen[id]) begin
			proto_cnt++;
			$display("ERROR %s: pixel %0d was delivered twice", cur_name, id);
		end else begin
			seen[id] = 1'b1;
		end
	endtask

	task automatic check_color(input pixel_id_t id, input color_t got);
		if (int'(id) < PIXELS && got !== exp_color[id]) begin
			mismatch_cnt++;
			$display("MISMATCH %s: pixel %0d colour expected %06h, got %06h",
				cur_name, id, exp_color[id], got);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			mismatch_cnt++;
			$display("MISMATCH %s: %s expected %0d, got %0d", cur_name, what, expected, actual);
		end
	endtask

	// One full frame, from the start edge until the queue stays empty
	task automatic run_frame();
		int   cyc;
		int   reads;
		int   missing;
		int   i;
		logic prev_read;
		logic frame_over;

		build_expected();
		@(negedge clk);
		cam_x = coord_t'(v_cam_x);
		cam_y = coord_t'(v_cam_y);
		cam_z = coord_t'(v_cam_z);
		box_xmin = coord_t'(v_xmin);
		box_xmax = coord_t'(v_xmax);
		box_ymin = coord_t'(v_ymin);
		box_ymax = coord_t'(v_ymax);
		box_zmin = coord_t'(v_zmin);
		pix_stall = 1'b0;
		start = 1'b1;
		cyc = 0;
		while (!busy && cyc < START_TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (!busy) begin
			timeout_cnt++;
			$display("TIMEOUT %s: busy did not rise after start", cur_name);
			start = 1'b0;
			aborted = 1'b1;
			return;
		end
		check_count("cycles from start to busy", 1, cyc);

		cyc = 0;
		reads = 0;
		prev_read = 1'b0;
		frame_over = 1'b0;
		while (!frame_over && cyc < FRAME_TIMEOUT) begin
			@(negedge clk);
			cyc++;
			// Second start edge mid frame, which must change nothing
			start = (cyc >= 20 && cyc < 23);
			pix_stall = draw_stall(density);
			#1;
			if (frame_done) begin
				frame_over = 1'b1;
				if (!prev_read) begin
					proto_cnt++;
					$display("ERROR %s: frame_done pulsed without a read in the cycle before",
						cur_name);
				end
				if (busy) begin
					proto_cnt++;
					$display("ERROR %s: busy still high when the frame ended", cur_name);
				end
			end else if (prev_read && reads == PIXELS) begin
				proto_cnt++;
				$display("ERROR %s: frame_done missing after the last read", cur_name);
			end
			prev_read = pix_valid && !pix_stall;
			if (prev_read) begin
				check_id(pix_id);
				check_color(pix_id, pix_color);
				reads++;
			end
		end
		if (!frame_over) begin
			timeout_cnt++;
			$display("TIMEOUT %s: frame not finished after %0d cycles, %0d pixels read",
				cur_name, FRAME_TIMEOUT, reads);
			start = 1'b0;
			aborted = 1'b1;
			return;
		end

		// Nothing may follow the end of the frame
		for (i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk);
			start = 1'b0;
			pix_stall = 1'b0;
			#1;
			if (pix_valid) begin
				proto_cnt++;
				$display("ERROR %s: pixel %0d appeared after the frame ended", cur_name, pix_id);
			end
			if (busy || frame_done) begin
				proto_cnt++;
				$display("ERROR %s: frame restarted or ended twice", cur_name);
			end
		end

		missing = 0;
		for (i = 0; i < PIXELS; i++) begin
			if (!seen[i]) missing++;
		end
		check_count("pixels read", PIXELS, reads);
		check_count("pixels never delivered", 0, missing);
	endtask

	initial begin
		int    fd;
		int    n;
		int    n_tests;
		string line;

		mismatch_cnt = 0;
		proto_cnt = 0;
		timeout_cnt = 0;
		aborted = 1'b0;
		n_tests = 0;
		lfsr_state = 16'd8;
		rst_n = 1'b0;
		start = 1'b0;
		cam_x = '0;
		cam_y = '0;
		cam_z = '0;
		box_xmin = '0;
		box_xmax = '0;
		box_ymin = '0;
		box_ymax = '0;
		box_zmin = '0;
		pix_stall = 1'b0;

		repeat (3) @(negedge clk);
		if (busy || frame_done || pix_valid) begin
			proto_cnt++;
			$display("ERROR: outputs not low during reset");
		end
		rst_n = 1'b1;

		fd = $fopen("dv/render_tests.txt", "r");
		if (fd == 0) begin
			proto_cnt++;
			$display("ERROR: could not open dv/render_tests.txt");
		end else begin
			while (!aborted && $fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == 8'h23) continue;
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d", cur_name,
					v_cam_x, v_cam_y, v_cam_z, v_xmin, v_xmax, v_ymin, v_ymax, v_zmin, density);
				if (n != 10) begin
					proto_cnt++;
					$display("ERROR: malformed test line: %s", line);
				end else begin
					n_tests++;
					$display("Running %s", cur_name);
					run_frame();
				end
			end
			$fclose(fd);
			if (n_tests == 0) begin
				proto_cnt++;
				$display("ERROR: no tests found in the test file");
			end
		end

		$display("Tests run %0d, mismatches %0d, other errors %0d, timeouts %0d",
			n_tests, mismatch_cnt, proto_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && proto_cnt == 0 && timeout_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule : render_tb

// File: hw/render_top.sv
// Ray casting render engine
`timescale 1ns/10ps

module render_top #(
	parameter int IMG_W = 16,
	parameter int IMG_H = 8,
	parameter int FIFO_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  rt_pkg::coord_t    cam_x,
	input  rt_pkg::coord_t    cam_y,
	input  rt_pkg::coord_t    cam_z,
	input  rt_pkg::coord_t    box_xmin,
	input  rt_pkg::coord_t    box_xmax,
	input  rt_pkg::coord_t    box_ymin,
	input  rt_pkg::coord_t    box_ymax,
	input  rt_pkg::coord_t    box_zmin,
	output logic              pix_valid,
	input  logic              pix_stall,
	output rt_pkg::pixel_id_t pix_id,
	output rt_pkg::color_t    pix_color,
	output logic              busy,
	output logic              frame_done
);
	import rt_pkg::*;

	localparam int PIXELS = IMG_W * IMG_H;

	logic      frame_start;
	logic      rd_strobe;
	logic      ray_valid;
	logic      ray_stall;
	pixel_id_t ray_id;
	coord_t    dir_x;
	coord_t    dir_y;
	logic      hit_valid;
	logic      hit_stall;
	pixel_id_t hit_id;
	logic      miss_valid;
	logic      miss_stall;
	pixel_id_t miss_id;
	logic      wr_en;
	logic      full;
	pixel_id_t wr_pixel_id;
	color_t    wr_color;
	logic      empty;

	assign pix_valid = !empty;
	assign rd_strobe = pix_valid && !pix_stall;

	frame_sequencer #(.PIXELS(PIXELS)) u_seq (
		.clk, .rst_n, .start, .rd_strobe, .frame_start, .busy, .frame_done
	);

	ray_gen #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_ray_gen (
		.clk, .rst_n, .frame_start, .ray_valid, .ray_stall, .ray_id, .dir_x, .dir_y
	);

	scene_int u_scene_int (
		.clk, .rst_n,
		.ray_valid, .ray_stall, .ray_id, .dir_x, .dir_y,
		.cam_x, .cam_y, .cam_z,
		.box_xmin, .box_xmax, .box_ymin, .box_ymax, .box_zmin,
		.hit_valid, .hit_stall, .hit_id,
		.miss_valid, .miss_stall, .miss_id
	);

	pixel_arbiter u_arb (
		.clk, .rst_n,
		.hit_valid, .hit_stall, .hit_id,
		.miss_valid, .miss_stall, .miss_id,
		.wr_en, .full, .wr_pixel_id, .wr_color
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk, .rst_n, .wr_en, .wr_pixel_id, .wr_color, .full,
		.rd_en(rd_strobe), .rd_pixel_id(pix_id), .rd_color(pix_color), .empty
	);

endmodule : render_top

// File: hw/pixel_fifo.sv
// Pixel output queue
`timescale 1ns/10ps

module pixel_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  rt_pkg::pixel_id_t wr_pixel_id,
	input  rt_pkg::color_t    wr_color,
	output logic              full,
	input  logic              rd_en,
	output rt_pkg::pixel_id_t rd_pixel_id,
	output rt_pkg::color_t    rd_color,
	output logic              empty
);
	import rt_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	pixel_id_t id_mem [FIFO_DEPTH];
	color_t    color_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// A read in the same cycle frees a slot, so full only stalls when nothing leaves
	assign full = (count == CNT_W'(FIFO_DEPTH)) && !rd_en;
	assign empty = (count == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign rd_pixel_id = id_mem[rd_ptr];
	assign rd_color = color_mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			if (do_wr && !do_rd) count <= count + CNT_W'(1);
			else if (do_rd && !do_wr) count <= count - CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			id_mem[wr_ptr] <= wr_pixel_id;
			color_mem[wr_ptr] <= wr_color;
		end
	end

endmodule : pixel_fifo

// File: hw/pixel_arbiter.sv
// Hit and miss stream merge
`timescale 1ns/10ps

module pixel_arbiter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              hit_valid,
	output logic              hit_stall,
	input  rt_pkg::pixel_id_t hit_id,
	input  logic              miss_valid,
	output logic              miss_stall,
	input  rt_pkg::pixel_id_t miss_id,
	output logic              wr_en,
	input  logic              full,
	output rt_pkg::pixel_id_t wr_pixel_id,
	output rt_pkg::color_t    wr_color
);
	import rt_pkg::*;

	route_e    last_grant;
	logic      can_load;
	logic      sel_hit;
	logic      sel_miss;
	logic      out_valid;
	pixel_id_t out_id;
	color_t    out_color;

	// Output register drains and refills in the same cycle
	assign can_load = !out_valid || !full;

	// Alternate when both sides want the queue
	assign sel_hit = hit_valid && (!miss_valid || (last_grant == ROUTE_MISS));
	assign sel_miss = miss_valid && !sel_hit;

	assign hit_stall = hit_valid && !(can_load && sel_hit);
	assign miss_stall = miss_valid && !(can_load && sel_miss);

	assign wr_en = out_valid;
	assign wr_pixel_id = out_id;
	assign wr_color = out_color;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			last_grant <= ROUTE_MISS;
		end else if (can_load) begin
			out_valid <= sel_hit || sel_miss;
			if (sel_hit) last_grant <= ROUTE_HIT;
			else if (sel_miss) last_grant <= ROUTE_MISS;
		end
	end

	always_ff @(posedge clk) begin
		if (can_load && sel_hit) begin
			out_id <= hit_id;
			out_color <= HIT_COLOR;
		end else if (can_load && sel_miss) begin
			out_id <= miss_id;
			out_color <= MISS_COLOR;
		end
	end

endmodule : pixel_arbiter

// File: hw/scene_int.sv
// Ray and box intersection
`timescale 1ns/10ps

module scene_int (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              ray_valid,
	output logic              ray_stall,
	input  rt_pkg::pixel_id_t ray_id,
	input  rt_pkg::coord_t    dir_x,
	input  rt_pkg::coord_t    dir_y,

	input  rt_pkg::coord_t    cam_x,
	input  rt_pkg::coord_t    cam_y,
	input  rt_pkg::coord_t    cam_z,
	input  rt_pkg::coord_t    box_xmin,
	input  rt_pkg::coord_t    box_xmax,
	input  rt_pkg::coord_t    box_ymin,
	input  rt_pkg::coord_t    box_ymax,
	input  rt_pkg::coord_t    box_zmin,

	output logic              hit_valid,
	input  logic              hit_stall,
	output rt_pkg::pixel_id_t hit_id,

	output logic              miss_valid,
	input  logic              miss_stall,
	output rt_pkg::pixel_id_t miss_id
);
	import rt_pkg::*;

	// Distance to the front face plane and the point where the ray crosses it
	logic signed [31:0] t_w;
	logic signed [31:0] px_w;
	logic signed [31:0] py_w;

	logic               s1_valid;
	logic               s1_stall;
	pixel_id_t          s1_id;
	logic               s1_t_pos;
	logic signed [31:0] s1_px;
	logic signed [31:0] s1_py;

	logic               in_x;
	logic               in_y;
	route_e             route_w;

	logic               s2_valid;
	logic               s2_stall;
	pixel_id_t          s2_id;
	route_e             s2_route;

	assign t_w = box_zmin - cam_z;
	assign px_w = cam_x + dir_x * t_w;
	assign py_w = cam_y + dir_y * t_w;

	assign in_x = (s1_px >= box_xmin) && (s1_px <= box_xmax);
	assign in_y = (s1_py >= box_ymin) && (s1_py <= box_ymax);
	assign route_w = (s1_t_pos && in_x && in_y) ? ROUTE_HIT : ROUTE_MISS;

	// Only the port the ray is routed to can hold the pipeline
	assign s2_stall = s2_valid && ((s2_route == ROUTE_HIT) ? hit_stall : miss_stall);
	assign s1_stall = s1_valid && s2_stall;
	assign ray_stall = s1_stall;

	assign hit_valid = s2_valid && (s2_route == ROUTE_HIT);
	assign miss_valid = s2_valid && (s2_route == ROUTE_MISS);
	assign hit_id = s2_id;
	assign miss_id = s2_id;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (!s1_stall) s1_valid <= ray_valid;
			if (!s2_stall) s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!s1_stall && ray_valid) begin
			s1_id <= ray_id;
			s1_t_pos <= (t_w > 0);
			s1_px <= px_w;
			s1_py <= py_w;
		end
		if (!s2_stall && s1_valid) begin
			s2_id <= s1_id;
			s2_route <= route_w;
		end
	end

endmodule : scene_int

// File: hw/ray_gen.sv
// Primary ray generator
`timescale 1ns/10ps

module ray_gen #(
	parameter int IMG_W = 16,
	parameter int IMG_H = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             frame_start,
	output logic             ray_valid,
	input  logic             ray_stall,
	output rt_pkg::pixel_id_t ray_id,
	output rt_pkg::coord_t   dir_x,
	output rt_pkg::coord_t   dir_y
);
	import rt_pkg::*;

	coord_t    x_pos;
	coord_t    y_pos;
	pixel_id_t pix_id;
	logic      active;
	logic      xfer;
	logic      last_col;
	logic      last_pix;

	assign xfer = active && !ray_stall;
	assign last_col = (x_pos == coord_t'(IMG_W - 1));
	assign last_pix = last_col && (y_pos == coord_t'(IMG_H - 1));

	// Image centre sits on the optical axis, z direction is always 1
	assign dir_x = x_pos - coord_t'(IMG_W / 2);
	assign dir_y = y_pos - coord_t'(IMG_H / 2);
	assign ray_id = pix_id;
	assign ray_valid = active;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			x_pos <= '0;
			y_pos <= '0;
			pix_id <= '0;
		end else if (frame_start) begin
			active <= 1'b1;
			x_pos <= '0;
			y_pos <= '0;
			pix_id <= '0;
		end else if (xfer) begin
			// Raster order, row by row
			if (last_pix) begin
				active <= 1'b0;
			end else if (last_col) begin
				x_pos <= '0;
				y_pos <= y_pos + coord_t'(1);
			end else begin
				x_pos <= x_pos + coord_t'(1);
			end
			pix_id <= pix_id + pixel_id_t'(1);
		end
	end

endmodule : ray_gen

// File: hw/frame_sequencer.sv
// Frame start and end control
`timescale 1ns/10ps

module frame_sequencer #(
	parameter int PIXELS = 128
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic rd_strobe,
	output logic frame_start,
	output logic busy,
	output logic frame_done
);
	import rt_pkg::*;

	localparam int CNT_W = $clog2(PIXELS + 1);

	seq_state_e state;
	logic start_q;
	logic start_edge;
	logic last_read;
	logic [CNT_W-1:0] rd_count;

	// Rising edge of start, only acted on while idle
	assign start_edge = start && !start_q;
	assign last_read = rd_strobe && (rd_count == CNT_W'(PIXELS - 1));
	assign busy = (state == SEQ_BUSY);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			start_q <= 1'b0;
			rd_count <= '0;
			frame_start <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			start_q <= start;
			frame_start <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (start_edge) begin
						state <= SEQ_BUSY;
						frame_start <= 1'b1;
						rd_count <= '0;
					end
				end
				SEQ_BUSY: begin
					// Count pixels leaving the queue until the whole image is out
					if (last_read) begin
						state <= SEQ_IDLE;
						frame_done <= 1'b1;
						rd_count <= '0;
					end else if (rd_strobe) begin
						rd_count <= rd_count + CNT_W'(1);
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule : frame_sequencer

// File: hw/rt_pkg.sv
// Ray caster shared types
package rt_pkg;

	// Signed scene coordinate, also used for ray directions
	typedef logic signed [15:0] coord_t;

	// Pixel index, y * IMG_W + x
	typedef logic [15:0] pixel_id_t;

	// 8 bits each of red, green, blue
	typedef logic [23:0] color_t;

	// Which arbiter input a pixel came from
	typedef enum logic {
		ROUTE_HIT,
		ROUTE_MISS
	} route_e;

	// Frame sequencer states
	typedef enum logic {
		SEQ_IDLE,
		SEQ_BUSY
	} seq_state_e;

	// Box surface is drawn white
	localparam color_t HIT_COLOR = 24'hFF_FF_FF;

	// Background is drawn blue
	localparam color_t MISS_COLOR = 24'h00_00_FF;

endpackage : rt_pkg
